//--- verilog/rename_pkg.sv
package rename_pkg;

    // architectural register file size.
    localparam int NUM_AREG_DEF = 32;

    // physical pool, sized so preg_t covers it.
    localparam int NUM_PREG_DEF = 64;

    localparam int FETCH_WIDTH_DEF = 2; // rename lanes.
    localparam int COMMIT_WIDTH_DEF = 2; // retire lanes.

    // x0 index is 0 and never renamed.
    typedef logic [4:0] areg_t;

    // physical index, 6 bits whatever the pool size.
    typedef logic [5:0] preg_t;

    // lane counts for allocation and rewind.
    typedef logic [2:0] lane_cnt_t;

endpackage

//--- verilog/rename_if.sv
`timescale 1ns/1ps

interface rename_req_if #(
    parameter int LANES = rename_pkg::FETCH_WIDTH_DEF
);
    rename_pkg::areg_t [LANES-1:0] vrs1;
    rename_pkg::areg_t [LANES-1:0] vrs2;
    rename_pkg::areg_t [LANES-1:0] vrd;
    logic [LANES-1:0] rd_we;
    rename_pkg::preg_t [LANES-1:0] prs1; // after the group bypass.
    rename_pkg::preg_t [LANES-1:0] prs2;
    rename_pkg::preg_t [LANES-1:0] prd;
    rename_pkg::preg_t [LANES-1:0] old_prd;
    logic [LANES-1:0] map_we;
    rename_pkg::areg_t [LANES-1:0] map_vrd;
    rename_pkg::preg_t [LANES-1:0] map_prd;
    rename_pkg::preg_t [LANES-1:0] table_prs1; // raw map reads.
    rename_pkg::preg_t [LANES-1:0] table_prs2;
    rename_pkg::preg_t [LANES-1:0] table_old;

    modport unit (input vrs1, vrs2, vrd, rd_we,
                  output prs1, prs2, prd, old_prd, map_we, map_vrd, map_prd);
    modport tbl (input vrs1, vrs2, vrd, map_we, map_vrd, map_prd,
                 output table_prs1, table_prs2, table_old);
endinterface

interface commit_if #(
    parameter int LANES = rename_pkg::COMMIT_WIDTH_DEF
);
    logic [LANES-1:0] en;
    rename_pkg::areg_t [LANES-1:0] vrd;
    rename_pkg::preg_t [LANES-1:0] prd;
    rename_pkg::preg_t [LANES-1:0] old_prd;
    logic walk;
    logic [LANES-1:0] walk_en; // highest lane is the youngest.
    rename_pkg::areg_t [LANES-1:0] walk_vrd;
    rename_pkg::preg_t [LANES-1:0] walk_old_prd;

    modport map (input en, vrd, prd, walk, walk_en, walk_vrd, walk_old_prd);
    modport pool (input en, old_prd, walk, walk_en);
endinterface

//--- verilog/rat_bank.sv
`timescale 1ns/1ps

module rat_bank #(
    parameter int RPORTS = 2,
    parameter int WPORTS = 2
) (
    input logic clk,
    input logic rst,
    input rename_pkg::areg_t [RPORTS-1:0] raddr,
    output rename_pkg::preg_t [RPORTS-1:0] rdata,
    input logic [WPORTS-1:0] we,
    input rename_pkg::areg_t [WPORTS-1:0] waddr,
    input rename_pkg::preg_t [WPORTS-1:0] wdata
);

    rename_pkg::preg_t map [rename_pkg::NUM_AREG_DEF];

    // later ports overwrite earlier ones on the same entry.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::NUM_AREG_DEF; i++) begin
                map[i] <= rename_pkg::preg_t'(i); // identity.
            end
        end else begin
            for (int p = 0; p < WPORTS; p++) begin
                if (we[p] && waddr[p] != '0) begin
                    map[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < RPORTS; r++) begin
            rdata[r] = map[raddr[r]];
        end
    end

endmodule

//--- verilog/rename_table.sv
`timescale 1ns/1ps

module rename_table #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH_DEF
) (
    input logic clk,
    input logic rst,
    rename_req_if.tbl req,
    commit_if.map cm,
    input rename_pkg::areg_t arch_vreg,
    output rename_pkg::preg_t arch_preg
);

    localparam int SPEC_W = (FETCH_WIDTH > COMMIT_WIDTH) ? FETCH_WIDTH : COMMIT_WIDTH;

    logic [SPEC_W-1:0] spec_we;
    rename_pkg::areg_t [SPEC_W-1:0] spec_waddr;
    rename_pkg::preg_t [SPEC_W-1:0] spec_wdata;
    rename_pkg::preg_t [2*FETCH_WIDTH-1:0] src_rdata;
    logic [COMMIT_WIDTH-1:0] waw [COMMIT_WIDTH];
    logic [COMMIT_WIDTH-1:0] commit_cancel;
    logic [COMMIT_WIDTH-1:0] commit_we;

    // walk lanes go in reversed so the oldest walked lane lands on the top port.
    always_comb begin
        spec_we = '0;
        spec_waddr = '0;
        spec_wdata = '0;
        if (cm.walk) begin
            for (int l = 0; l < COMMIT_WIDTH; l++) begin
                spec_we[COMMIT_WIDTH-1-l] = cm.walk_en[l];
                spec_waddr[COMMIT_WIDTH-1-l] = cm.walk_vrd[l];
                spec_wdata[COMMIT_WIDTH-1-l] = cm.walk_old_prd[l];
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                spec_we[i] = req.map_we[i];
                spec_waddr[i] = req.map_vrd[i];
                spec_wdata[i] = req.map_prd[i];
            end
        end
    end

    // two copies of the speculative map split by read port.
    rat_bank #(.RPORTS(2*FETCH_WIDTH), .WPORTS(SPEC_W)) src_bank (
        .clk(clk),
        .rst(rst),
        .raddr({req.vrs2, req.vrs1}),
        .rdata(src_rdata),
        .we(spec_we),
        .waddr(spec_waddr),
        .wdata(spec_wdata)
    );

    rat_bank #(.RPORTS(FETCH_WIDTH), .WPORTS(SPEC_W)) dst_bank (
        .clk(clk),
        .rst(rst),
        .raddr(req.vrd),
        .rdata(req.table_old),
        .we(spec_we),
        .waddr(spec_waddr),
        .wdata(spec_wdata)
    );

    assign req.table_prs1 = src_rdata[FETCH_WIDTH-1:0];
    assign req.table_prs2 = src_rdata[2*FETCH_WIDTH-1:FETCH_WIDTH];

    // waw[i][j] set when younger lane j hits the same vrd as lane i.
    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : g_waw
        for (genvar j = 0; j < COMMIT_WIDTH; j++) begin : g_col
            if (j > i) begin : g_upper
                assign waw[i][j] = cm.en[i] && cm.en[j] && (cm.vrd[i] == cm.vrd[j]);
            end else begin : g_lower
                assign waw[i][j] = 1'b0;
            end
        end
        assign commit_cancel[i] = |waw[i];
    end

    assign commit_we = cm.en & ~commit_cancel;

    rat_bank #(.RPORTS(1), .WPORTS(COMMIT_WIDTH)) arch_bank (
        .clk(clk),
        .rst(rst),
        .raddr(arch_vreg),
        .rdata(arch_preg),
        .we(commit_we),
        .waddr(cm.vrd),
        .wdata(cm.prd)
    );

endmodule

//--- verilog/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int NUM_PREG = rename_pkg::NUM_PREG_DEF,
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH_DEF
) (
    input logic clk,
    input logic rst,
    input logic [FETCH_WIDTH-1:0] alloc,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0] alloc_preg,
    output logic [6:0] free_count,
    commit_if.pool cm
);

    localparam int DEPTH = NUM_PREG - rename_pkg::NUM_AREG_DEF;
    localparam int PW = $clog2(DEPTH);

    rename_pkg::preg_t fl [DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] tail; // next slot to release into.
    logic [6:0] count;
    rename_pkg::lane_cnt_t n_alloc;
    rename_pkg::lane_cnt_t n_rel;
    rename_pkg::lane_cnt_t n_walk;
    logic [PW-1:0] rel_slot [COMMIT_WIDTH];
    logic [COMMIT_WIDTH-1:0] rel_we;

    // pointer step, wraps at DEPTH in either direction.
    function automatic logic [PW-1:0] wrap_add(input logic [PW-1:0] p, input int k);
        int s;
        s = int'(p) + k;
        if (s >= DEPTH) begin
            s = s - DEPTH;
        end else if (s < 0) begin
            s = s + DEPTH;
        end
        return PW'(s);
    endfunction

    always_comb begin
        rename_pkg::lane_cnt_t off;
        off = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            alloc_preg[i] = fl[wrap_add(head, int'(off))];
            off = off + rename_pkg::lane_cnt_t'(alloc[i]);
        end
        n_alloc = off;
        off = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            rel_we[i] = cm.en[i] && cm.old_prd[i] != '0; // p0 stays out of the pool.
            rel_slot[i] = wrap_add(tail, int'(off));
            off = off + rename_pkg::lane_cnt_t'(rel_we[i]);
        end
        n_rel = off;
        n_walk = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            n_walk = n_walk + rename_pkg::lane_cnt_t'(cm.walk && cm.walk_en[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= 7'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                fl[i] <= rename_pkg::preg_t'(rename_pkg::NUM_AREG_DEF + i);
            end
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (rel_we[i]) begin
                    fl[rel_slot[i]] <= cm.old_prd[i];
                end
            end
            // walked entries are still in the queue, so rewind just moves head.
            head <= wrap_add(head, int'(n_alloc) - int'(n_walk));
            tail <= wrap_add(tail, int'(n_rel));
            count <= count + 7'(n_rel) + 7'(n_walk) - 7'(n_alloc);
        end
    end

    assign free_count = count;

endmodule

//--- verilog/rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF
) (
    input logic in_valid,
    output logic in_ready,
    input logic [6:0] free_count,
    output logic [FETCH_WIDTH-1:0] alloc,
    input rename_pkg::preg_t [FETCH_WIDTH-1:0] alloc_preg,
    input logic walk,
    rename_req_if.unit req,
    input rename_pkg::preg_t [FETCH_WIDTH-1:0] table_prs1,
    input rename_pkg::preg_t [FETCH_WIDTH-1:0] table_prs2,
    input rename_pkg::preg_t [FETCH_WIDTH-1:0] table_old
);

    logic [FETCH_WIDTH-1:0] needs;
    rename_pkg::lane_cnt_t need_cnt;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] lane_prd;
    logic fire;

    always_comb begin
        need_cnt = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            needs[i] = req.rd_we[i] && req.vrd[i] != '0;
            need_cnt = need_cnt + rename_pkg::lane_cnt_t'(needs[i]);
            lane_prd[i] = needs[i] ? alloc_preg[i] : '0; // x0 keeps p0.
        end
    end

    // stall during a walk or when the pool is short.
    assign in_ready = !walk && (free_count >= 7'(need_cnt));
    assign fire = in_valid && in_ready;
    assign alloc = needs & {FETCH_WIDTH{fire}};

    assign req.map_we = alloc;
    assign req.map_vrd = req.vrd;
    assign req.map_prd = alloc_preg;
    assign req.prd = lane_prd;

    // youngest older writer in the group overrides the map.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            req.prs1[i] = table_prs1[i];
            req.prs2[i] = table_prs2[i];
            req.old_prd[i] = table_old[i];
            for (int j = 0; j < i; j++) begin
                if (needs[j] && req.vrd[j] == req.vrs1[i]) begin
                    req.prs1[i] = lane_prd[j];
                end
                if (needs[j] && req.vrd[j] == req.vrs2[i]) begin
                    req.prs2[i] = lane_prd[j];
                end
                if (needs[j] && req.vrd[j] == req.vrd[i]) begin
                    req.old_prd[i] = lane_prd[j];
                end
            end
        end
    end

endmodule

//--- verilog/rename_top.sv
`timescale 1ns/1ps

module rename_top #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH_DEF,
    parameter int NUM_PREG = rename_pkg::NUM_PREG_DEF
) (
    input logic clk,
    input logic rst,
    input logic in_valid,
    output logic in_ready,
    input rename_pkg::areg_t [FETCH_WIDTH-1:0] vrs1,
    input rename_pkg::areg_t [FETCH_WIDTH-1:0] vrs2,
    input rename_pkg::areg_t [FETCH_WIDTH-1:0] vrd,
    input logic [FETCH_WIDTH-1:0] rd_we,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0] prs1,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0] prs2,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0] prd,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0] old_prd,
    input logic [COMMIT_WIDTH-1:0] commit_en,
    input rename_pkg::areg_t [COMMIT_WIDTH-1:0] commit_vrd,
    input rename_pkg::preg_t [COMMIT_WIDTH-1:0] commit_prd,
    input rename_pkg::preg_t [COMMIT_WIDTH-1:0] commit_old_prd,
    input logic walk,
    input logic [COMMIT_WIDTH-1:0] walk_en,
    input rename_pkg::areg_t [COMMIT_WIDTH-1:0] walk_vrd,
    input rename_pkg::preg_t [COMMIT_WIDTH-1:0] walk_old_prd,
    input rename_pkg::areg_t arch_vreg,
    output rename_pkg::preg_t arch_preg
);

    logic [6:0] free_count;
    logic [FETCH_WIDTH-1:0] alloc;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] alloc_preg;

    rename_req_if #(.LANES(FETCH_WIDTH)) req ();
    commit_if #(.LANES(COMMIT_WIDTH)) cm ();

    assign req.vrs1 = vrs1;
    assign req.vrs2 = vrs2;
    assign req.vrd = vrd;
    assign req.rd_we = rd_we;
    assign prs1 = req.prs1;
    assign prs2 = req.prs2;
    assign prd = req.prd;
    assign old_prd = req.old_prd;

    assign cm.en = commit_en;
    assign cm.vrd = commit_vrd;
    assign cm.prd = commit_prd;
    assign cm.old_prd = commit_old_prd;
    assign cm.walk = walk;
    assign cm.walk_en = walk_en;
    assign cm.walk_vrd = walk_vrd;
    assign cm.walk_old_prd = walk_old_prd;

    // map reads loop back through the unit for the group bypass.
    rename_unit #(.FETCH_WIDTH(FETCH_WIDTH)) unit_inst (
        .in_valid(in_valid),
        .in_ready(in_ready),
        .free_count(free_count),
        .alloc(alloc),
        .alloc_preg(alloc_preg),
        .walk(walk),
        .req(req.unit),
        .table_prs1(req.table_prs1),
        .table_prs2(req.table_prs2),
        .table_old(req.table_old)
    );

    rename_table #(.FETCH_WIDTH(FETCH_WIDTH), .COMMIT_WIDTH(COMMIT_WIDTH)) table_inst (
        .clk(clk),
        .rst(rst),
        .req(req.tbl),
        .cm(cm.map),
        .arch_vreg(arch_vreg),
        .arch_preg(arch_preg)
    );

    free_list #(
        .NUM_PREG(NUM_PREG),
        .FETCH_WIDTH(FETCH_WIDTH),
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) free_list_inst (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .alloc_preg(alloc_preg),
        .free_count(free_count),
        .cm(cm.pool)
    );

endmodule

//--- testbench/rename_properties.sv
`timescale 1ns/1ps

module rename_properties #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int NUM_PREG = rename_pkg::NUM_PREG_DEF
) (
    input logic clk,
    input logic rst,
    input logic walk,
    input logic in_valid,
    input logic in_ready,
    input logic [FETCH_WIDTH-1:0] rd_we,
    input rename_pkg::areg_t [FETCH_WIDTH-1:0] vrd,
    input rename_pkg::preg_t [FETCH_WIDTH-1:0] prd,
    input logic [6:0] free_count
);

    stall_on_walk: assert property (@(posedge clk) disable iff (rst) walk |-> !in_ready)
        else $error("in_ready high during a walk");

    pool_bound: assert property (@(posedge clk) disable iff (rst)
        free_count <= 7'(NUM_PREG - rename_pkg::NUM_AREG_DEF))
        else $error("free_count %0d above pool size", free_count);

    // a fired lane with a real destination never gets p0.
    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_lane
        fired_prd: assert property (@(posedge clk) disable iff (rst)
            (in_valid && in_ready && rd_we[i] && vrd[i] != '0) |-> prd[i] != '0)
            else $error("lane %0d fired with prd 0", i);
    end

endmodule

bind rename_top rename_properties #(
    .FETCH_WIDTH(FETCH_WIDTH),
    .NUM_PREG(NUM_PREG)
) props_inst (
    .clk(clk),
    .rst(rst),
    .walk(walk),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .rd_we(rd_we),
    .vrd(vrd),
    .prd(prd),
    .free_count(free_count)
);

//--- testbench/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

    localparam int MAX_CYCLES = 2 * 1000; // twice the summed test budget.

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    rename_pkg::areg_t [1:0] vrs1;
    rename_pkg::areg_t [1:0] vrs2;
    rename_pkg::areg_t [1:0] vrd;
    logic [1:0] rd_we;
    rename_pkg::preg_t [1:0] prs1;
    rename_pkg::preg_t [1:0] prs2;
    rename_pkg::preg_t [1:0] prd;
    rename_pkg::preg_t [1:0] old_prd;
    logic [1:0] commit_en;
    rename_pkg::areg_t [1:0] commit_vrd;
    rename_pkg::preg_t [1:0] commit_prd;
    rename_pkg::preg_t [1:0] commit_old_prd;
    logic walk;
    logic [1:0] walk_en;
    rename_pkg::areg_t [1:0] walk_vrd;
    rename_pkg::preg_t [1:0] walk_old_prd;
    rename_pkg::areg_t arch_vreg;
    rename_pkg::preg_t arch_preg;

    // reference model.
    rename_pkg::preg_t spec [32];
    rename_pkg::preg_t arch [32];
    rename_pkg::preg_t fq [32];
    int fq_head;
    int fq_tail;
    int fq_count;
    rename_pkg::areg_t [1:0] hist_d [128]; // renamed groups in age order.
    rename_pkg::preg_t [1:0] hist_prd [128];
    rename_pkg::preg_t [1:0] hist_old [128];
    logic [1:0] hist_need [128];
    int hist_n;
    int commit_ptr;
    rename_pkg::preg_t [1:0] obs_prd; // last values seen on the DUT.
    rename_pkg::preg_t [1:0] obs_old;
    rename_pkg::preg_t [1:0] obs_prs1;
    rename_pkg::preg_t obs_arch;
    logic [31:0] lfsr;
    int errors;
    int checks;
    int cycles;

    rename_top rename_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic rename_pkg::areg_t random_areg();
        rename_pkg::areg_t r;
        r = '0;
        for (int i = 0; i < 5; i++) begin
            r = {r[3:0], lfsr[0]}; // one step per bit.
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic rename_pkg::areg_t nonzero_areg();
        rename_pkg::areg_t r;
        r = random_areg();
        return (r == '0) ? 5'd1 : r;
    endfunction

    task automatic compare_preg(input string name, input rename_pkg::preg_t got,
                                input rename_pkg::preg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        $display("%s: %0d errors", name, errors - e0);
    endtask

    // expected values come from the model before the group fires.
    task automatic rename_group(input rename_pkg::areg_t [1:0] s1,
                                input rename_pkg::areg_t [1:0] s2,
                                input rename_pkg::areg_t [1:0] d, input logic [1:0] we);
        logic [1:0] need;
        rename_pkg::preg_t [1:0] lane_prd;
        rename_pkg::preg_t [1:0] e1;
        rename_pkg::preg_t [1:0] e2;
        rename_pkg::preg_t [1:0] eold;
        int off;
        logic ready;
        off = 0;
        for (int i = 0; i < 2; i++) begin
            need[i] = we[i] && d[i] != '0;
            lane_prd[i] = need[i] ? fq[(fq_head + off) % 32] : '0;
            off = off + int'(need[i]);
            e1[i] = spec[s1[i]];
            e2[i] = spec[s2[i]];
            eold[i] = spec[d[i]];
            for (int j = 0; j < i; j++) begin
                if (need[j] && d[j] == s1[i]) begin
                    e1[i] = lane_prd[j];
                end
                if (need[j] && d[j] == s2[i]) begin
                    e2[i] = lane_prd[j];
                end
                if (need[j] && d[j] == d[i]) begin
                    eold[i] = lane_prd[j];
                end
            end
        end
        ready = (fq_count >= off);
        @(posedge clk);
        in_valid <= 1'b1;
        vrs1 <= s1;
        vrs2 <= s2;
        vrd <= d;
        rd_we <= we;
        commit_en <= '0;
        walk <= 1'b0;
        @(negedge clk);
        compare_bit("in_ready", in_ready, ready);
        if (ready) begin
            for (int i = 0; i < 2; i++) begin
                compare_preg($sformatf("prs1[%0d]", i), prs1[i], e1[i]);
                compare_preg($sformatf("prs2[%0d]", i), prs2[i], e2[i]);
                compare_preg($sformatf("prd[%0d]", i), prd[i], lane_prd[i]);
                compare_preg($sformatf("old_prd[%0d]", i), old_prd[i], eold[i]);
            end
            obs_prd = prd;
            obs_old = old_prd;
            obs_prs1 = prs1;
            hist_d[hist_n] = d;
            hist_prd[hist_n] = lane_prd;
            hist_old[hist_n] = eold;
            hist_need[hist_n] = need;
            hist_n++;
            for (int i = 0; i < 2; i++) begin
                if (need[i]) begin
                    spec[d[i]] = lane_prd[i];
                    fq_head = (fq_head + 1) % 32;
                    fq_count--;
                end
            end
        end
    endtask

    task automatic retire_group(input int g);
        @(posedge clk);
        in_valid <= 1'b0;
        walk <= 1'b0;
        commit_en <= hist_need[g];
        commit_vrd <= hist_d[g];
        commit_prd <= hist_prd[g];
        commit_old_prd <= hist_old[g];
        for (int i = 0; i < 2; i++) begin
            if (hist_need[g][i]) begin
                arch[hist_d[g][i]] = hist_prd[g][i]; // lane 1 lands last.
                if (hist_old[g][i] != '0) begin
                    fq[fq_tail] = hist_old[g][i];
                    fq_tail = (fq_tail + 1) % 32;
                    fq_count++;
                end
            end
        end
    endtask

    task automatic retire_all();
        while (commit_ptr < hist_n) begin
            retire_group(commit_ptr);
            commit_ptr++;
        end
    endtask

    task automatic walk_group(input int g);
        int n;
        n = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        commit_en <= '0;
        walk <= 1'b1;
        walk_en <= hist_need[g];
        walk_vrd <= hist_d[g];
        walk_old_prd <= hist_old[g];
        @(negedge clk);
        compare_bit("in_ready", in_ready, 1'b0);
        for (int i = 1; i >= 0; i--) begin
            if (hist_need[g][i]) begin
                spec[hist_d[g][i]] = hist_old[g][i];
                n++;
            end
        end
        fq_head = (fq_head - n + 32) % 32;
        fq_count = fq_count + n;
    endtask

    task automatic peek_map(input rename_pkg::areg_t r);
        @(posedge clk);
        in_valid <= 1'b0;
        commit_en <= '0;
        walk <= 1'b0;
        rd_we <= '0;
        vrs1 <= {r, r};
        vrs2 <= {~r, ~r};
        arch_vreg <= r;
        @(negedge clk);
        compare_preg("prs1[0]", prs1[0], spec[r]);
        compare_preg("prs1[1]", prs1[1], spec[r]);
        compare_preg("prs2[0]", prs2[0], spec[~r]);
        compare_preg("prs2[1]", prs2[1], spec[~r]);
        compare_preg("arch_preg", arch_preg, arch[r]);
        obs_prs1 = prs1;
        obs_arch = arch_preg;
    endtask

    task automatic reset_identity();
        int e0;
        e0 = errors;
        for (int r = 0; r < 32; r++) begin
            peek_map(rename_pkg::areg_t'(r));
        end
        finish_test("reset_identity", e0);
    endtask

    task automatic group_renames();
        int e0;
        rename_pkg::areg_t [1:0] d;
        rename_pkg::areg_t prev;
        e0 = errors;
        prev = 5'd3;
        for (int k = 0; k < 8; k++) begin
            d = {random_areg(), random_areg()};
            rename_group({random_areg(), prev}, {random_areg(), random_areg()}, d, 2'b11);
            prev = d[1]; // next group reads it back.
        end
        d = {nonzero_areg(), 5'd0};
        rename_group({random_areg(), prev}, {random_areg(), random_areg()}, d, 2'b11);
        compare_preg("prd[0]", obs_prd[0], '0);
        peek_map(d[1]);
        peek_map(5'd0);
        finish_test("group_renames", e0);
    endtask

    task automatic group_bypass();
        int e0;
        rename_pkg::preg_t p9;
        e0 = errors;
        rename_group({5'd5, 5'd2}, {5'd6, 5'd4}, {5'd11, 5'd5}, 2'b11);
        compare_preg("prs1[1]", obs_prs1[1], hist_prd[hist_n-1][0]);
        rename_group({5'd1, 5'd2}, {5'd3, 5'd4}, {5'd9, 5'd9}, 2'b11);
        compare_preg("old_prd[1]", obs_old[1], hist_prd[hist_n-1][0]);
        p9 = hist_prd[hist_n-1][1];
        peek_map(5'd9);
        compare_preg("prs1[0]", obs_prs1[0], p9);
        finish_test("group_bypass", e0);
    endtask

    task automatic commit_update();
        int e0;
        int g;
        e0 = errors;
        g = hist_n;
        rename_group({random_areg(), random_areg()}, {random_areg(), random_areg()},
                     {5'd7, 5'd7}, 2'b11);
        retire_all();
        for (int r = 0; r < 32; r++) begin
            peek_map(rename_pkg::areg_t'(r));
        end
        peek_map(5'd7);
        compare_preg("arch_preg", obs_arch, hist_prd[g][1]); // younger lane wins.
        finish_test("commit_update", e0);
    endtask

    task automatic pool_stall();
        int e0;
        e0 = errors;
        while (fq_count >= 2) begin
            rename_group({random_areg(), random_areg()}, {random_areg(), random_areg()},
                         {nonzero_areg(), nonzero_areg()}, 2'b11);
        end
        // pool too short so in_ready drops.
        rename_group({random_areg(), random_areg()}, {random_areg(), random_areg()},
                     {nonzero_areg(), nonzero_areg()}, 2'b11);
        repeat (3) begin
            retire_group(commit_ptr);
            commit_ptr++;
        end
        repeat (3) begin
            rename_group({random_areg(), random_areg()}, {random_areg(), random_areg()},
                         {nonzero_areg(), nonzero_areg()}, 2'b11);
        end
        finish_test("pool_stall", e0);
    endtask

    task automatic walk_restore();
        int e0;
        int g;
        rename_pkg::preg_t saved [32];
        rename_pkg::areg_t [1:0] sa;
        rename_pkg::areg_t [1:0] da;
        rename_pkg::areg_t [1:0] db;
        rename_pkg::preg_t [1:0] pa;
        rename_pkg::preg_t [1:0] pb;
        e0 = errors;
        retire_all();
        saved = spec;
        g = hist_n;
        sa = {random_areg(), random_areg()};
        da[0] = nonzero_areg();
        da[1] = da[0]; // both lanes hit one register so the walk order matters.
        db = {nonzero_areg(), nonzero_areg()};
        rename_group(sa, sa, da, 2'b11);
        pa = hist_prd[g];
        rename_group(sa, sa, db, 2'b01);
        pb = hist_prd[g + 1];
        walk_group(g + 1);
        walk_group(g);
        hist_n = g;
        for (int r = 0; r < 32; r++) begin
            peek_map(rename_pkg::areg_t'(r));
            compare_preg("prs1[0]", obs_prs1[0], saved[r]);
        end
        rename_group(sa, sa, da, 2'b11);
        compare_preg("prd[0]", obs_prd[0], pa[0]);
        compare_preg("prd[1]", obs_prd[1], pa[1]);
        rename_group(sa, sa, db, 2'b01);
        compare_preg("prd[0]", obs_prd[0], pb[0]);
        finish_test("walk_restore", e0);
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        vrs1 = '0;
        vrs2 = '0;
        vrd = '0;
        rd_we = '0;
        commit_en = '0;
        commit_vrd = '0;
        commit_prd = '0;
        commit_old_prd = '0;
        walk = 1'b0;
        walk_en = '0;
        walk_vrd = '0;
        walk_old_prd = '0;
        arch_vreg = '0;
        lfsr = 32'h261fb7da;
        errors = 0;
        checks = 0;
        cycles = 0;
        hist_n = 0;
        commit_ptr = 0;
        fq_head = 0;
        fq_tail = 0;
        fq_count = 32;
        for (int i = 0; i < 32; i++) begin
            spec[i] = rename_pkg::preg_t'(i);
            arch[i] = rename_pkg::preg_t'(i);
            fq[i] = rename_pkg::preg_t'(32 + i);
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_identity();
        group_renames();
        group_bypass();
        commit_update();
        pool_stall();
        walk_restore();
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- all.f
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/rat_bank.sv
verilog/rename_table.sv
verilog/free_list.sv
verilog/rename_unit.sv
verilog/rename_top.sv
testbench/rename_properties.sv
testbench/rename_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rename_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
